//--- verilog/csr_pkg.sv
package csr_pkg;

    // data width of the core
    localparam int XLEN = 32;

    // ####################
    // instruction fields
    // ####################

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 of ecall, mret and the other privileged words
    localparam logic [2:0] F3_PRIV = 3'b000;

    // ####################
    // csr addresses
    // ####################

    localparam logic [11:0] CSR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;

    // read-modify-write function
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // funct3-000 system instruction kinds
    typedef enum logic [1:0] {
        SYS_NONE    = 2'd0,
        SYS_ECALL   = 2'd1,
        SYS_MRET    = 2'd2,
        SYS_ILLEGAL = 2'd3
    } sys_kind_e;

    // ####################
    // mstatus layout
    // ####################

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    // MIE, MPIE and the two MPP bits
    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;

    // machine mode encoding for MPP
    localparam logic [1:0] MPP_MACHINE = 2'b11;

    // trap causes
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

endpackage

//--- verilog/csr_access.sv
`timescale 1ns/100ps

module csr_access (
    input  logic               i_valid,
    input  logic [31:0]        i_inst,
    output logic               o_acc_valid,
    output logic [11:0]        o_acc_addr,
    output csr_pkg::csr_op_e   o_acc_op,
    output logic               o_acc_wr,
    output logic               o_acc_uimm,
    output logic [4:0]         o_acc_zimm,
    output logic               o_acc_illegal
);
    import csr_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  src_field;
    logic [11:0] addr;
    logic        is_csr;
    logic        known_addr;
    logic        read_only;
    csr_op_e     op;
    logic        wr_req;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign src_field = i_inst[19:15];
    assign addr      = i_inst[31:20];

    // every SYSTEM word except the funct3-000 group
    assign is_csr = i_valid && (opcode == OPC_SYSTEM) && (funct3 != F3_PRIV);

    // low two funct3 bits pick the function, bit 2 the immediate form
    always_comb begin
        case (funct3[1:0])
            2'b01:   op = CSR_WRITE;
            2'b10:   op = CSR_SET;
            2'b11:   op = CSR_CLEAR;
            default: op = CSR_NONE;
        endcase
    end

    always_comb begin
        case (addr)
            CSR_MSTATUS,
            CSR_MTVEC,
            CSR_MSCRATCH,
            CSR_MEPC,
            CSR_MCAUSE,
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MHARTID: known_addr = 1'b1;
            default:     known_addr = 1'b0;
        endcase
    end

    // top two address bits 11 mark a read-only csr
    assign read_only = (addr[11:10] == 2'b11);

    // set and clear with a zero source only read
    assign wr_req = (op == CSR_WRITE) ||
                    (((op == CSR_SET) || (op == CSR_CLEAR)) && (src_field != 5'd0));

    assign o_acc_valid   = is_csr;
    assign o_acc_addr    = addr;
    assign o_acc_op      = is_csr ? op : CSR_NONE;
    assign o_acc_wr      = is_csr && wr_req;
    assign o_acc_uimm    = funct3[2];
    assign o_acc_zimm    = src_field;
    assign o_acc_illegal = is_csr &&
                           ((op == CSR_NONE) || !known_addr || (wr_req && read_only));

endmodule

//--- verilog/trap_ctrl.sv
`timescale 1ns/100ps

module trap_ctrl (
    input  logic                 i_valid,
    input  logic [31:0]          i_inst,
    output csr_pkg::sys_kind_e   o_sys_kind
);
    import csr_pkg::*;

    // full instruction words
    localparam logic [31:0] INST_ECALL = 32'h0000_0073;
    localparam logic [31:0] INST_MRET  = 32'h3020_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_priv;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];

    assign is_priv = i_valid && (opcode == OPC_SYSTEM) && (funct3 == F3_PRIV);

    always_comb begin
        if (!is_priv) begin
            o_sys_kind = SYS_NONE;
        end else if (i_inst == INST_ECALL) begin
            o_sys_kind = SYS_ECALL;
        end else if (i_inst == INST_MRET) begin
            o_sys_kind = SYS_MRET;
        end else begin
            // ebreak, wfi, sret and the rest are not supported
            o_sys_kind = SYS_ILLEGAL;
        end
    end

endmodule

//--- verilog/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile #(
    parameter logic [31:0] MVENDORID = 32'h0,
    parameter logic [31:0] MARCHID   = 32'h0,
    parameter logic [31:0] HART_ID   = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [csr_pkg::XLEN-1:0]   i_pc,
    input  logic [csr_pkg::XLEN-1:0]   i_rs1_data,
    input  logic                       i_acc_valid,
    input  logic [11:0]                i_acc_addr,
    input  csr_pkg::csr_op_e           i_acc_op,
    input  logic                       i_acc_wr,
    input  logic                       i_acc_uimm,
    input  logic [4:0]                 i_acc_zimm,
    input  logic                       i_acc_illegal,
    input  csr_pkg::sys_kind_e         i_sys_kind,
    output logic [csr_pkg::XLEN-1:0]   o_rd_data,
    output logic                       o_illegal,
    output logic                       o_redirect,
    output logic [csr_pkg::XLEN-1:0]   o_redirect_pc,
    output logic [csr_pkg::XLEN-1:0]   o_mstatus,
    output logic [csr_pkg::XLEN-1:0]   o_mtvec,
    output logic [csr_pkg::XLEN-1:0]   o_mepc
);
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic            illegal;
    logic            trap;
    logic            ret;
    logic            csr_we;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] new_val;
    logic [XLEN-1:0] mstatus_trap;
    logic [XLEN-1:0] mstatus_ret;

    // ####################
    // request priority
    // ####################

    assign illegal    = i_acc_illegal || (i_sys_kind == SYS_ILLEGAL);
    assign trap       = illegal || (i_sys_kind == SYS_ECALL);
    assign ret        = !trap && (i_sys_kind == SYS_MRET);
    assign csr_we     = i_acc_valid && i_acc_wr && !trap && !ret;
    assign trap_cause = illegal ? CAUSE_ILLEGAL : CAUSE_ECALL_M;

    // ####################
    // read and modify
    // ####################

    always_comb begin
        case (i_acc_addr)
            CSR_MSTATUS:   old_val = mstatus_q;
            CSR_MTVEC:     old_val = mtvec_q;
            CSR_MSCRATCH:  old_val = mscratch_q;
            CSR_MEPC:      old_val = mepc_q;
            CSR_MCAUSE:    old_val = mcause_q;
            CSR_MVENDORID: old_val = MVENDORID;
            CSR_MARCHID:   old_val = MARCHID;
            CSR_MHARTID:   old_val = HART_ID;
            default:       old_val = '0;
        endcase
    end

    // zimm is zero-extended
    assign operand = i_acc_uimm ? {{(XLEN-5){1'b0}}, i_acc_zimm} : i_rs1_data;

    always_comb begin
        case (i_acc_op)
            CSR_WRITE: new_val = operand;
            CSR_SET:   new_val = old_val | operand;
            CSR_CLEAR: new_val = old_val & ~operand;
            default:   new_val = old_val;
        endcase
    end

    // mstatus stack on trap entry and on mret
    always_comb begin
        mstatus_trap                      = mstatus_q;
        mstatus_trap[MSTATUS_MPIE]        = mstatus_q[MSTATUS_MIE];
        mstatus_trap[MSTATUS_MIE]         = 1'b0;
        mstatus_trap[MSTATUS_MPP_LO +: 2] = MPP_MACHINE;

        mstatus_ret                       = mstatus_q;
        mstatus_ret[MSTATUS_MIE]          = mstatus_q[MSTATUS_MPIE];
        mstatus_ret[MSTATUS_MPIE]         = 1'b1;
        mstatus_ret[MSTATUS_MPP_LO +: 2]  = 2'b00;
    end

    // ####################
    // csr state
    // ####################

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q <= '0;
        end else if (trap) begin
            mstatus_q <= mstatus_trap;
        end else if (ret) begin
            mstatus_q <= mstatus_ret;
        end else if (csr_we && (i_acc_addr == CSR_MSTATUS)) begin
            mstatus_q <= new_val & MSTATUS_WMASK;
        end
    end

    // direct mode only, base is word aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec_q <= '0;
        end else if (csr_we && (i_acc_addr == CSR_MTVEC)) begin
            mtvec_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch_q <= '0;
        end else if (csr_we && (i_acc_addr == CSR_MSCRATCH)) begin
            mscratch_q <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc_q <= '0;
        end else if (trap) begin
            mepc_q <= i_pc;
        end else if (csr_we && (i_acc_addr == CSR_MEPC)) begin
            mepc_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcause_q <= '0;
        end else if (trap) begin
            mcause_q <= trap_cause;
        end else if (csr_we && (i_acc_addr == CSR_MCAUSE)) begin
            mcause_q <= new_val;
        end
    end

    // old value goes to rd, nothing on an illegal access
    assign o_rd_data     = (i_acc_valid && !illegal) ? old_val : '0;
    assign o_illegal     = illegal;
    assign o_redirect    = trap || ret;
    assign o_redirect_pc = trap ? mtvec_q : mepc_q;
    assign o_mstatus     = mstatus_q;
    assign o_mtvec       = mtvec_q;
    assign o_mepc        = mepc_q;

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/100ps

module csr_unit #(
    parameter logic [31:0] MVENDORID = 32'h0,
    parameter logic [31:0] MARCHID   = 32'h0,
    parameter logic [31:0] HART_ID   = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_valid,
    input  logic [31:0]                i_inst,
    input  logic [csr_pkg::XLEN-1:0]   i_pc,
    input  logic [csr_pkg::XLEN-1:0]   i_rs1_data,
    output logic [csr_pkg::XLEN-1:0]   o_rd_data,
    output logic                       o_illegal,
    output logic                       o_redirect,
    output logic [csr_pkg::XLEN-1:0]   o_redirect_pc,
    output logic [csr_pkg::XLEN-1:0]   o_mstatus,
    output logic [csr_pkg::XLEN-1:0]   o_mtvec,
    output logic [csr_pkg::XLEN-1:0]   o_mepc
);
    import csr_pkg::*;

    logic        acc_valid;
    logic [11:0] acc_addr;
    csr_op_e     acc_op;
    logic        acc_wr;
    logic        acc_uimm;
    logic [4:0]  acc_zimm;
    logic        acc_illegal;
    sys_kind_e   sys_kind;

    // zicsr decode
    csr_access u_access (
        .i_valid       (i_valid),
        .i_inst        (i_inst),
        .o_acc_valid   (acc_valid),
        .o_acc_addr    (acc_addr),
        .o_acc_op      (acc_op),
        .o_acc_wr      (acc_wr),
        .o_acc_uimm    (acc_uimm),
        .o_acc_zimm    (acc_zimm),
        .o_acc_illegal (acc_illegal)
    );

    // ecall, mret and the rest of funct3 000
    trap_ctrl u_trap (
        .i_valid    (i_valid),
        .i_inst     (i_inst),
        .o_sys_kind (sys_kind)
    );

    csr_regfile #(
        .MVENDORID (MVENDORID),
        .MARCHID   (MARCHID),
        .HART_ID   (HART_ID)
    ) u_regfile (
        .clk           (clk),
        .reset         (reset),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .i_acc_valid   (acc_valid),
        .i_acc_addr    (acc_addr),
        .i_acc_op      (acc_op),
        .i_acc_wr      (acc_wr),
        .i_acc_uimm    (acc_uimm),
        .i_acc_zimm    (acc_zimm),
        .i_acc_illegal (acc_illegal),
        .i_sys_kind    (sys_kind),
        .o_rd_data     (o_rd_data),
        .o_illegal     (o_illegal),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mstatus     (o_mstatus),
        .o_mtvec       (o_mtvec),
        .o_mepc        (o_mepc)
    );

endmodule

//--- tests/csr_unit_chk.sv
`timescale 1ns/100ps

module csr_unit_chk (
    input logic                       clk,
    input logic                       reset,
    input logic                       i_acc_valid,
    input csr_pkg::sys_kind_e         i_sys_kind,
    input logic                       o_illegal,
    input logic                       o_redirect,
    input logic [csr_pkg::XLEN-1:0]   mtvec_q,
    input logic [csr_pkg::XLEN-1:0]   mscratch_q,
    input logic [csr_pkg::XLEN-1:0]   mcause_q
);
    import csr_pkg::*;

    // a redirect and a csr write never share a cycle
    redirect_no_write: assert property (@(posedge clk) disable iff (reset)
        o_redirect |=> ($stable(mtvec_q) && $stable(mscratch_q)))
        else $error("csr written during a redirect");

    illegal_traps: assert property (@(posedge clk) disable iff (reset)
        o_illegal |-> o_redirect ##1 (mcause_q == CAUSE_ILLEGAL))
        else $error("illegal instruction without a trap of cause 2");

    // no request, no redirect
    quiet_no_redirect: assert property (@(posedge clk) disable iff (reset)
        (!i_acc_valid && (i_sys_kind == SYS_NONE)) |-> !o_redirect)
        else $error("redirect without any request");

endmodule

bind csr_regfile csr_unit_chk u_chk (
    .clk         (clk),
    .reset       (reset),
    .i_acc_valid (i_acc_valid),
    .i_sys_kind  (i_sys_kind),
    .o_illegal   (o_illegal),
    .o_redirect  (o_redirect),
    .mtvec_q     (mtvec_q),
    .mscratch_q  (mscratch_q),
    .mcause_q    (mcause_q)
);

//--- tests/tb_csr_unit.sv
`timescale 1ns/100ps

module tb_csr_unit;

    localparam int          NUM_TESTS   = 3000;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] P_MVENDORID = 32'h0000_0B0B;
    localparam logic [31:0] P_MARCHID   = 32'h0000_0017;
    localparam logic [31:0] P_HART_ID   = 32'h0000_0003;
    localparam logic [6:0]  SYSTEM      = 7'b1110011;
    localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;

    logic        clk;
    logic        reset;
    logic        i_valid;
    logic [31:0] i_inst;
    logic [31:0] i_pc;
    logic [31:0] i_rs1_data;
    logic [31:0] o_rd_data;
    logic        o_illegal;
    logic        o_redirect;
    logic [31:0] o_redirect_pc;
    logic [31:0] o_mstatus;
    logic [31:0] o_mtvec;
    logic [31:0] o_mepc;

    logic [31:0] lfsr;
    int          errors;
    logic [11:0] addr_list [8];

    // model copies of the writable csrs
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    csr_unit #(
        .MVENDORID (P_MVENDORID),
        .MARCHID   (P_MARCHID),
        .HART_ID   (P_HART_ID)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .i_valid       (i_valid),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .o_rd_data     (o_rd_data),
        .o_illegal     (o_illegal),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mstatus     (o_mstatus),
        .o_mtvec       (o_mtvec),
        .o_mepc        (o_mepc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr, output logic known);
        known = 1'b1;
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'hF11: return P_MVENDORID;
            12'hF12: return P_MARCHID;
            12'hF14: return P_HART_ID;
            default: begin
                known = 1'b0;
                return 32'h0;
            end
        endcase
    endfunction

    // drive one cycle, check the same-cycle outputs, then update the model
    task automatic run_cycle(input logic valid, input logic [31:0] inst,
                             input logic [31:0] pc, input logic [31:0] rs1);
        logic [2:0]  f3;
        logic [11:0] addr;
        logic [31:0] old;
        logic [31:0] opnd;
        logic [31:0] nv;
        logic        known;
        logic        is_sys;
        logic        wr;
        logic        illegal;
        logic        ecall;
        logic        mret;
        logic        csr_acc;
        logic [31:0] exp_rd;
        @(posedge clk);
        #1;
        i_valid    = valid;
        i_inst     = inst;
        i_pc       = pc;
        i_rs1_data = rs1;
        #4;
        f3      = inst[14:12];
        addr    = inst[31:20];
        is_sys  = valid && (inst[6:0] == SYSTEM);
        csr_acc = is_sys && (f3 != 3'b000);
        old     = model_read(addr, known);
        wr      = (f3[1:0] == 2'b01) || (f3[1:0] != 2'b00 && inst[19:15] != 5'd0);
        ecall   = is_sys && (inst == 32'h0000_0073);
        mret    = is_sys && (inst == 32'h3020_0073);
        illegal = (csr_acc && (f3[1:0] == 2'b00 || !known || (wr && addr[11:10] == 2'b11)))
                  || (is_sys && f3 == 3'b000 && !ecall && !mret);
        exp_rd  = (csr_acc && !illegal) ? old : 32'h0;

        check_value("rd_data", exp_rd, o_rd_data);
        check_value("illegal", {31'b0, illegal}, {31'b0, o_illegal});
        check_value("redirect", {31'b0, illegal || ecall || mret}, {31'b0, o_redirect});
        if (illegal || ecall) begin
            check_value("trap_pc", m_mtvec, o_redirect_pc);
        end else if (mret) begin
            check_value("mret_pc", m_mepc, o_redirect_pc);
        end
        check_value("mstatus", m_mstatus, o_mstatus);
        check_value("mtvec", m_mtvec, o_mtvec);
        check_value("mepc", m_mepc, o_mepc);

        opnd = f3[2] ? {27'b0, inst[19:15]} : rs1;
        case (f3[1:0])
            2'b01:   nv = opnd;
            2'b10:   nv = old | opnd;
            2'b11:   nv = old & ~opnd;
            default: nv = old;
        endcase

        if (illegal || ecall) begin
            m_mepc       = pc;
            m_mcause     = illegal ? 32'd2 : 32'd11;
            m_mstatus[7] = m_mstatus[3];
            m_mstatus[3] = 1'b0;
            m_mstatus[12:11] = 2'b11;
        end else if (mret) begin
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
            m_mstatus[12:11] = 2'b00;
        end else if (csr_acc && wr) begin
            case (addr)
                12'h300: m_mstatus  = nv & 32'h0000_1888;
                12'h305: m_mtvec    = {nv[31:2], 2'b00};
                12'h340: m_mscratch = nv;
                12'h341: m_mepc     = {nv[31:2], 2'b00};
                12'h342: m_mcause   = nv;
                default: ;
            endcase
        end
    endtask

    // ####################
    // stimulus
    // ####################

    initial begin
        logic [2:0]  cls;
        logic [11:0] addr;
        logic [31:0] inst;
        logic [6:0]  opc;
        logic        valid;
        lfsr = 32'h461cbfcd;
        errors = 0;
        addr_list = '{12'h300, 12'h305, 12'h340, 12'h341, 12'h342, 12'hF11, 12'hF12, 12'hF14};
        m_mstatus = '0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        reset = 1'b1;
        i_valid = 1'b0;
        i_inst = '0;
        i_pc = '0;
        i_rs1_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // writable csrs read back 0 after reset
        for (int i = 0; i < 5; i++) begin
            run_cycle(1'b1, {addr_list[i], 5'd0, 3'b010, 5'd1, SYSTEM}, 32'h0, 32'h0);
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            cls = rand_bits(3);
            if (rand_bits(2) == 0) begin
                addr = rand_bits(12);
            end else begin
                addr = addr_list[rand_bits(3)];
            end
            case (cls)
                3'd4: inst = 32'h0000_0073;
                3'd5: inst = 32'h3020_0073;
                3'd6: inst = {17'(rand_bits(17)), 3'b000, 5'(rand_bits(5)), SYSTEM};
                3'd7: begin
                    opc = rand_bits(7);
                    if (opc == SYSTEM) begin
                        opc = 7'b0110011;
                    end
                    inst = {25'(rand_bits(25)), opc};
                end
                default: inst = {addr, 5'(rand_bits(5)), 3'(rand_bits(3)),
                                 5'(rand_bits(5)), SYSTEM};
            endcase
            valid = (rand_bits(3) != 0);
            run_cycle(valid, inst, {30'(rand_bits(30)), 2'b00}, rand_bits(32));
        end

        // idle cycle shows the last update
        run_cycle(1'b0, 32'h0, 32'h0, 32'h0);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RESET_CYCLES + NUM_TESTS * 4) * 10);
        $display("timeout: the test sequence did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- src.f
verilog/csr_pkg.sv
verilog/csr_access.sv
verilog/trap_ctrl.sv
verilog/csr_regfile.sv
verilog/csr_unit.sv
tests/csr_unit_chk.sv
tests/tb_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
